// File: common/riscv_pkg.sv
package riscv_pkg;

  localparam int xlen = 32;
  localparam logic [xlen-1:0] reset_pc = 32'h0000_0000;
  localparam int imem_awidth = 10;  // Word address, 4 KB
  localparam int dmem_awidth = 10;
  localparam logic [11:0] csr_tohost = 12'h51e;

  localparam logic [6:0] op_lui    = 7'b0110111;
  localparam logic [6:0] op_auipc  = 7'b0010111;
  localparam logic [6:0] op_jal    = 7'b1101111;
  localparam logic [6:0] op_jalr   = 7'b1100111;
  localparam logic [6:0] op_branch = 7'b1100011;
  localparam logic [6:0] op_load   = 7'b0000011;
  localparam logic [6:0] op_store  = 7'b0100011;
  localparam logic [6:0] op_imm    = 7'b0010011;
  localparam logic [6:0] op_reg    = 7'b0110011;
  localparam logic [6:0] op_system = 7'b1110011;

  typedef enum logic [3:0] {
    alu_add, alu_sub, alu_sll, alu_slt, alu_sltu,
    alu_xor, alu_srl, alu_sra, alu_or, alu_and
  } alu_op_e;

  typedef enum logic [1:0] {wb_alu, wb_mem, wb_pc4, wb_csr} wb_sel_e;

  // Instruction formats, MSB first
  typedef struct packed {
    logic [6:0] funct7; logic [4:0] rs2; logic [4:0] rs1;
    logic [2:0] funct3; logic [4:0] rd; logic [6:0] opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0] imm; logic [4:0] rs1; logic [2:0] funct3;
    logic [4:0] rd; logic [6:0] opcode;
  } i_fmt_t;

  typedef struct packed {
    logic [6:0] imm_hi; logic [4:0] rs2; logic [4:0] rs1;
    logic [2:0] funct3; logic [4:0] imm_lo; logic [6:0] opcode;
  } s_fmt_t;

  typedef struct packed {
    logic imm12; logic [5:0] imm10_5; logic [4:0] rs2; logic [4:0] rs1;
    logic [2:0] funct3; logic [3:0] imm4_1; logic imm11; logic [6:0] opcode;
  } b_fmt_t;

  typedef struct packed {
    logic [19:0] imm; logic [4:0] rd; logic [6:0] opcode;
  } u_fmt_t;

  typedef struct packed {
    logic imm20; logic [9:0] imm10_1; logic imm11; logic [7:0] imm19_12;
    logic [4:0] rd; logic [6:0] opcode;
  } j_fmt_t;

  typedef union packed {
    r_fmt_t r_fmt;
    i_fmt_t i_fmt;
    s_fmt_t s_fmt;
    b_fmt_t b_fmt;
    u_fmt_t u_fmt;
    j_fmt_t j_fmt;
  } instr_u;

  typedef struct packed {
    logic       reg_we;
    logic       mem_we;
    logic       mem_rd;
    alu_op_e    alu_op;
    logic       src_a_pc;   // ALU operand A is the PC
    logic       src_b_imm;  // ALU operand B is the immediate
    logic       is_branch;
    logic       is_jal;
    logic       is_jalr;
    logic       csr_we;
    wb_sel_e    wb_sel;
    logic [2:0] funct3;
  } ctrl_t;

  typedef struct packed {
    logic            valid;
    ctrl_t           ctrl;
    logic [xlen-1:0] pc;
    logic [4:0]      rs1_addr;
    logic [4:0]      rs2_addr;
    logic [xlen-1:0] rs1_data;
    logic [xlen-1:0] rs2_data;
    logic [xlen-1:0] imm;
    logic [4:0]      rd;
  } id_ex_t;

  typedef struct packed {
    logic            valid;
    logic            reg_we;
    wb_sel_e         wb_sel;
    logic [2:0]      funct3;
    logic [4:0]      rd;
    logic [xlen-1:0] result;
    logic [xlen-1:0] csr_old;
    logic [1:0]      byte_off;
  } ex_wb_t;

  typedef struct packed {
    logic            taken;
    logic [xlen-1:0] target;
  } redirect_t;

  typedef struct packed {
    logic                   we;
    logic [imem_awidth-1:0] addr;
    logic [xlen-1:0]        data;
  } prog_write_t;

  typedef struct packed {
    logic            we;
    logic [4:0]      rd;
    logic [xlen-1:0] data;
  } wb_t;

endpackage

// File: source/sync_ram_wbe.sv
module sync_ram_wbe import riscv_pkg::*; #(
  parameter int awidth = imem_awidth
) (
  input  logic              clk,
  input  logic [awidth-1:0] addr,
  input  logic [xlen-1:0]   d,
  input  logic [3:0]        wbe,
  output logic [xlen-1:0]   q
);
  logic [xlen-1:0] mem [2**awidth];

  // One cycle read latency, returns the old word on a write
  always_ff @(posedge clk) begin
    for (int i = 0; i < 4; i++) begin
      if (wbe[i]) begin
        mem[addr][8*i +: 8] <= d[8*i +: 8];
      end
    end
    q <= mem[addr];
  end

endmodule

// File: fetch/fetch_unit.sv
module fetch_unit import riscv_pkg::*; (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            run,
  input  redirect_t       redirect,
  output logic [xlen-1:0] pc,
  output logic [xlen-1:0] if_pc,
  output logic            if_valid
);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc       <= reset_pc;
      if_valid <= 1'b0;
    end else if (!run) begin
      pc       <= reset_pc;  // Restart from the top on the next run
      if_valid <= 1'b0;
    end else begin
      pc       <= redirect.taken ? redirect.target : pc + 32'd4;
      // Word fetched this cycle is wrong-path when EX redirects
      if_valid <= !redirect.taken;
    end
  end

  // Follows the imem read latency
  always_ff @(posedge clk) begin
    if_pc <= pc;
  end

endmodule

// File: decode/reg_file.sv
module reg_file import riscv_pkg::*; (
  input  logic            clk,
  input  logic            rst_n,
  input  logic [4:0]      rs1_addr,
  input  logic [4:0]      rs2_addr,
  output logic [xlen-1:0] rs1_data,
  output logic [xlen-1:0] rs2_data,
  input  wb_t             wb
);
  logic [xlen-1:0] regs [1:31];
  logic            wr_en;

  assign wr_en = wb.we && wb.rd != 5'd0;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en) begin
      regs[wb.rd] <= wb.data;
    end
  end

  // Write-through covers the instruction two ahead in WB
  assign rs1_data = (rs1_addr == 5'd0) ? '0 :
                    (wr_en && wb.rd == rs1_addr) ? wb.data : regs[rs1_addr];
  assign rs2_data = (rs2_addr == 5'd0) ? '0 :
                    (wr_en && wb.rd == rs2_addr) ? wb.data : regs[rs2_addr];

endmodule

// File: decode/decode_stage.sv
module decode_stage import riscv_pkg::*; (
  input  logic            clk,
  input  logic            rst_n,
  input  logic [31:0]     instr,
  input  logic [xlen-1:0] if_pc,
  input  logic            if_valid,
  input  wb_t             wb,
  input  logic            flush,
  output id_ex_t          id_ex
);
  instr_u          ins;
  ctrl_t           ctrl;
  logic [xlen-1:0] imm;
  logic [4:0]      rs1_addr;
  logic [xlen-1:0] rs1_data, rs2_data;

  function automatic alu_op_e alu_decode(input logic [2:0] f3, input logic alt);
    case (f3)
      3'b000:  return alt ? alu_sub : alu_add;
      3'b001:  return alu_sll;
      3'b010:  return alu_slt;
      3'b011:  return alu_sltu;
      3'b100:  return alu_xor;
      3'b101:  return alt ? alu_sra : alu_srl;
      3'b110:  return alu_or;
      default: return alu_and;
    endcase
  endfunction

  assign ins = instr;

  always_comb begin
    ctrl        = '0;
    ctrl.alu_op = alu_add;
    ctrl.wb_sel = wb_alu;
    ctrl.funct3 = ins.r_fmt.funct3;
    imm         = '0;
    rs1_addr    = ins.r_fmt.rs1;
    case (ins.r_fmt.opcode)
      op_lui: begin
        ctrl.reg_we    = 1'b1;
        ctrl.src_b_imm = 1'b1;
        rs1_addr       = '0;  // x0 + imm
        imm            = {ins.u_fmt.imm, 12'b0};
      end
      op_auipc: begin
        ctrl.reg_we    = 1'b1;
        ctrl.src_a_pc  = 1'b1;
        ctrl.src_b_imm = 1'b1;
        imm            = {ins.u_fmt.imm, 12'b0};
      end
      op_jal: begin
        ctrl.reg_we    = 1'b1;
        ctrl.is_jal    = 1'b1;
        ctrl.src_a_pc  = 1'b1;
        ctrl.src_b_imm = 1'b1;
        ctrl.wb_sel    = wb_pc4;
        imm = {{11{ins.j_fmt.imm20}}, ins.j_fmt.imm20, ins.j_fmt.imm19_12,
               ins.j_fmt.imm11, ins.j_fmt.imm10_1, 1'b0};
      end
      op_jalr: begin
        ctrl.reg_we    = 1'b1;
        ctrl.is_jalr   = 1'b1;
        ctrl.src_b_imm = 1'b1;
        ctrl.wb_sel    = wb_pc4;
        imm            = {{20{ins.i_fmt.imm[11]}}, ins.i_fmt.imm};
      end
      op_branch: begin
        ctrl.is_branch = 1'b1;
        ctrl.src_a_pc  = 1'b1;  // ALU makes the target
        ctrl.src_b_imm = 1'b1;
        imm = {{19{ins.b_fmt.imm12}}, ins.b_fmt.imm12, ins.b_fmt.imm11,
               ins.b_fmt.imm10_5, ins.b_fmt.imm4_1, 1'b0};
      end
      op_load: begin
        ctrl.reg_we    = 1'b1;
        ctrl.mem_rd    = 1'b1;
        ctrl.src_b_imm = 1'b1;
        ctrl.wb_sel    = wb_mem;
        imm            = {{20{ins.i_fmt.imm[11]}}, ins.i_fmt.imm};
      end
      op_store: begin
        ctrl.mem_we    = 1'b1;
        ctrl.src_b_imm = 1'b1;
        imm = {{20{ins.s_fmt.imm_hi[6]}}, ins.s_fmt.imm_hi, ins.s_fmt.imm_lo};
      end
      op_imm: begin
        ctrl.reg_we    = 1'b1;
        ctrl.src_b_imm = 1'b1;
        // Only SRAI uses the alternate encoding, SUB has no immediate form
        ctrl.alu_op = alu_decode(ins.i_fmt.funct3,
                                 ins.i_fmt.funct3 == 3'b101 && ins.i_fmt.imm[10]);
        imm = {{20{ins.i_fmt.imm[11]}}, ins.i_fmt.imm};
      end
      op_reg: begin
        ctrl.reg_we = 1'b1;
        ctrl.alu_op = alu_decode(ins.r_fmt.funct3, ins.r_fmt.funct7[5]);
      end
      op_system: begin
        // CSRRW and CSRRWI to tohost, other CSRs act as no-ops
        if (ins.i_fmt.funct3[1:0] == 2'b01 && ins.i_fmt.imm == csr_tohost) begin
          ctrl.reg_we    = 1'b1;
          ctrl.csr_we    = 1'b1;
          ctrl.src_b_imm = 1'b1;
          ctrl.wb_sel    = wb_csr;
          if (ins.i_fmt.funct3[2]) begin
            rs1_addr = '0;  // zimm passes through the ALU as 0 + imm
            imm      = {{(xlen-5){1'b0}}, ins.i_fmt.rs1};
          end
        end
      end
      default: ;
    endcase
  end

  reg_file u_reg_file (
    .clk     (clk),
    .rst_n   (rst_n),
    .rs1_addr(rs1_addr),
    .rs2_addr(ins.r_fmt.rs2),
    .rs1_data(rs1_data),
    .rs2_data(rs2_data),
    .wb      (wb)
  );

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      id_ex <= '0;
    end else begin
      id_ex.valid    <= if_valid && !flush;
      id_ex.ctrl     <= ctrl;
      id_ex.pc       <= if_pc;
      id_ex.rs1_addr <= rs1_addr;
      id_ex.rs2_addr <= ins.r_fmt.rs2;
      id_ex.rs1_data <= rs1_data;
      id_ex.rs2_data <= rs2_data;
      id_ex.imm      <= imm;
      id_ex.rd       <= ins.r_fmt.rd;
    end
  end

endmodule

// File: execute/execute_stage.sv
module execute_stage import riscv_pkg::*; (
  input  logic            clk,
  input  logic            rst_n,
  input  id_ex_t          id_ex,
  input  wb_t             wb,
  output redirect_t       redirect,
  output logic [xlen-1:0] dmem_addr,
  output logic [xlen-1:0] store_data,
  output logic [3:0]      store_be,
  output ex_wb_t          ex_wb,
  output logic [31:0]     csr,
  output logic            csr_we
);
  ctrl_t           ctrl;
  logic [xlen-1:0] rs1, rs2, op_a, op_b, alu_out, tohost;
  logic            cond;

  assign ctrl = id_ex.ctrl;

  // WB forwarding, x0 is never forwarded
  assign rs1 = (wb.we && wb.rd != 5'd0 && wb.rd == id_ex.rs1_addr) ? wb.data : id_ex.rs1_data;
  assign rs2 = (wb.we && wb.rd != 5'd0 && wb.rd == id_ex.rs2_addr) ? wb.data : id_ex.rs2_data;

  assign op_a = ctrl.src_a_pc ? id_ex.pc : rs1;
  assign op_b = ctrl.src_b_imm ? id_ex.imm : rs2;

  always_comb begin
    case (ctrl.alu_op)
      alu_sub:  alu_out = op_a - op_b;
      alu_sll:  alu_out = op_a << op_b[4:0];
      alu_slt:  alu_out = {{(xlen-1){1'b0}}, $signed(op_a) < $signed(op_b)};
      alu_sltu: alu_out = {{(xlen-1){1'b0}}, op_a < op_b};
      alu_xor:  alu_out = op_a ^ op_b;
      alu_srl:  alu_out = op_a >> op_b[4:0];
      alu_sra:  alu_out = $signed(op_a) >>> op_b[4:0];
      alu_or:   alu_out = op_a | op_b;
      alu_and:  alu_out = op_a & op_b;
      default:  alu_out = op_a + op_b;
    endcase
  end

  always_comb begin
    case (ctrl.funct3)
      3'b000:  cond = rs1 == rs2;
      3'b001:  cond = rs1 != rs2;
      3'b100:  cond = $signed(rs1) < $signed(rs2);
      3'b101:  cond = $signed(rs1) >= $signed(rs2);
      3'b110:  cond = rs1 < rs2;
      3'b111:  cond = rs1 >= rs2;
      default: cond = 1'b0;
    endcase
  end

  assign redirect.taken  = id_ex.valid && (ctrl.is_jal || ctrl.is_jalr ||
                                           (ctrl.is_branch && cond));
  assign redirect.target = ctrl.is_jalr ? {alu_out[xlen-1:1], 1'b0} : alu_out;

  assign dmem_addr  = alu_out;
  assign store_data = rs2;
  assign store_be   = {4{id_ex.valid && ctrl.mem_we}};  // Lane mask comes from mem_align

  // tohost
  assign csr_we = id_ex.valid && ctrl.csr_we;
  assign csr    = csr_we ? alu_out : tohost;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      tohost <= '0;
      ex_wb  <= '0;
    end else begin
      if (csr_we) tohost <= alu_out;
      ex_wb.valid    <= id_ex.valid;
      ex_wb.reg_we   <= ctrl.reg_we;
      ex_wb.wb_sel   <= ctrl.wb_sel;
      ex_wb.funct3   <= ctrl.funct3;
      ex_wb.rd       <= id_ex.rd;
      ex_wb.result   <= (ctrl.wb_sel == wb_pc4) ? id_ex.pc + 32'd4 : alu_out;
      ex_wb.csr_old  <= tohost;
      ex_wb.byte_off <= ctrl.mem_rd ? alu_out[1:0] : 2'b00;
    end
  end

endmodule

// File: execute/mem_align.sv
module mem_align import riscv_pkg::*; (
  input  logic [xlen-1:0] st_data,
  input  logic [2:0]      funct3,
  input  logic [1:0]      byte_off,
  output logic [xlen-1:0] st_word,
  output logic [3:0]      st_be,
  input  logic [xlen-1:0] ld_word,
  input  logic [2:0]      ld_funct3,
  input  logic [1:0]      ld_off,
  output logic [xlen-1:0] ld_data
);
  logic [xlen-1:0] shifted;

  // Store side, data replicated so any lane enable picks it up
  always_comb begin
    case (funct3[1:0])
      2'b00: begin
        st_word = {4{st_data[7:0]}};
        st_be   = 4'b0001 << byte_off;
      end
      2'b01: begin
        st_word = {2{st_data[15:0]}};
        st_be   = 4'b0011 << {byte_off[1], 1'b0};
      end
      default: begin
        st_word = st_data;
        st_be   = 4'b1111;
      end
    endcase
  end

  // Load side
  assign shifted = ld_word >> {ld_off, 3'b000};

  always_comb begin
    case (ld_funct3)
      3'b000:  ld_data = {{24{shifted[7]}}, shifted[7:0]};    // LB
      3'b001:  ld_data = {{16{shifted[15]}}, shifted[15:0]};  // LH
      3'b100:  ld_data = {24'b0, shifted[7:0]};               // LBU
      3'b101:  ld_data = {16'b0, shifted[15:0]};              // LHU
      default: ld_data = shifted;
    endcase
  end

endmodule

// File: source/riscv_core.sv
module riscv_core import riscv_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        run,
  input  prog_write_t prog,
  output logic [31:0] csr,
  output logic        csr_we
);
  logic [xlen-1:0]        pc, if_pc;
  logic                   if_valid;
  logic [imem_awidth-1:0] imem_addr;
  logic [3:0]             imem_wbe;
  logic [xlen-1:0]        imem_q;
  redirect_t              redirect;
  id_ex_t                 id_ex;
  ex_wb_t                 ex_wb;
  wb_t                    wb;

  logic [xlen-1:0] dmem_addr, store_data, st_word, dmem_q, ld_data;
  logic [3:0]      store_be, st_be;

  fetch_unit u_fetch (
    .clk     (clk),
    .rst_n   (rst_n),
    .run     (run),
    .redirect(redirect),
    .pc      (pc),
    .if_pc   (if_pc),
    .if_valid(if_valid)
  );

  // Program loader owns the imem port while the core is stopped
  assign imem_addr = run ? pc[imem_awidth+1:2] : prog.addr;
  assign imem_wbe  = (prog.we && !run) ? 4'hf : 4'h0;

  sync_ram_wbe #(.awidth(imem_awidth)) u_imem (
    .clk (clk),
    .addr(imem_addr),
    .d   (prog.data),
    .wbe (imem_wbe),
    .q   (imem_q)
  );

  decode_stage u_decode (
    .clk     (clk),
    .rst_n   (rst_n),
    .instr   (imem_q),
    .if_pc   (if_pc),
    .if_valid(if_valid),
    .wb      (wb),
    .flush   (redirect.taken),  // Kill the ID slot behind a taken branch
    .id_ex   (id_ex)
  );

  execute_stage u_execute (
    .clk       (clk),
    .rst_n     (rst_n),
    .id_ex     (id_ex),
    .wb        (wb),
    .redirect  (redirect),
    .dmem_addr (dmem_addr),
    .store_data(store_data),
    .store_be  (store_be),
    .ex_wb     (ex_wb),
    .csr       (csr),
    .csr_we    (csr_we)
  );

  mem_align u_mem_align (
    .st_data  (store_data),
    .funct3   (id_ex.ctrl.funct3),
    .byte_off (dmem_addr[1:0]),
    .st_word  (st_word),
    .st_be    (st_be),
    .ld_word  (dmem_q),
    .ld_funct3(ex_wb.funct3),
    .ld_off   (ex_wb.byte_off),
    .ld_data  (ld_data)
  );

  sync_ram_wbe #(.awidth(dmem_awidth)) u_dmem (
    .clk (clk),
    .addr(dmem_addr[dmem_awidth+1:2]),
    .d   (st_word),
    .wbe (st_be & store_be),
    .q   (dmem_q)
  );

  // WB select
  always_comb begin
    wb.we = ex_wb.valid && ex_wb.reg_we;
    wb.rd = ex_wb.rd;
    case (ex_wb.wb_sel)
      wb_mem:  wb.data = ld_data;
      wb_csr:  wb.data = ex_wb.csr_old;
      default: wb.data = ex_wb.result;  // ALU or link address
    endcase
  end

endmodule

// File: tb/tb_clock.sv
module tb_clock (
  output logic clk,
  output logic rst_n
);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // Reset held over the first four rising edges
  initial begin
    rst_n = 1'b0;
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
  end

endmodule

// File: tb/tb_programs.svh
  // Encoders for the six formats
  function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3,
                                         input logic [4:0] rd);
    instr_u w;
    w.r_fmt = '{f7, rs2, rs1, f3, rd, op_reg};
    return w;
  endfunction

  function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                         input logic [2:0] f3, input logic [4:0] rd,
                                         input logic [6:0] op);
    instr_u w;
    w.i_fmt = '{imm, rs1, f3, rd, op};
    return w;
  endfunction

  function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3);
    instr_u w;
    w.s_fmt = '{imm[11:5], rs2, rs1, f3, imm[4:0], op_store};
    return w;
  endfunction

  function automatic logic [31:0] b_type(input logic [12:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3);
    instr_u w;
    w.b_fmt = '{imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], op_branch};
    return w;
  endfunction

  function automatic logic [31:0] u_type(input logic [19:0] imm, input logic [4:0] rd,
                                         input logic [6:0] op);
    instr_u w;
    w.u_fmt = '{imm, rd, op};
    return w;
  endfunction

  function automatic logic [31:0] j_type(input logic [20:0] imm, input logic [4:0] rd);
    instr_u w;
    w.j_fmt = '{imm[20], imm[10:1], imm[11], imm[19:12], rd, op_jal};
    return w;
  endfunction

  task automatic emit(input logic [31:0] word);
    prog_q.push_back(word);
  endtask

  function automatic logic [31:0] next_pc();
    return 32'(prog_q.size()) * 32'd4;
  endfunction

  // LUI then ADDI with the upper part rounded for the signed low half
  task automatic load_const(input logic [4:0] rd, input logic [31:0] value);
    logic [31:0] upper;
    upper = value + 32'h800;
    emit(u_type(upper[31:12], rd, op_lui));
    emit(i_type(value[11:0], rd, 3'b000, rd, op_imm));
  endtask

  task automatic write_tohost(input logic [4:0] rs);
    emit(i_type(csr_tohost, rs, 3'b001, 5'd0, op_system));  // CSRRW x0
  endtask

  task automatic write_tohost_imm(input logic [4:0] zimm);
    emit(i_type(csr_tohost, zimm, 3'b101, 5'd0, op_system));  // CSRRWI x0
  endtask

  task automatic read_back(input logic [2:0] f3, input logic [1:0] off,
                           input logic [31:0] word);
    emit(i_type({10'd0, off}, 5'd10, f3, 5'd13, op_load));
    write_tohost(5'd13);  // Load result used at once
    expect_q.push_back(load_extract(word, f3, off));
  endtask

  task automatic load_program();
    @(negedge clk);
    run = 1'b0;
    for (int i = 0; i < prog_q.size(); i++) begin
      prog.we   = 1'b1;
      prog.addr = imem_awidth'(i);
      prog.data = prog_q[i];
      @(negedge clk);
    end
    prog = '0;
  endtask

  task automatic collect_pulses(input string name, input int n);
    int got;
    int waited;
    got = 0;
    waited = 0;
    while (got < n && waited < 2000) begin
      @(negedge clk);
      waited++;
      if (csr_we) begin
        csr_seen.push_back(csr);
        got++;
        waited = 0;
      end
    end
    if (got < n) begin
      timeout_errors++;
      $display("%s: no CSR write arrived within 2000 cycles, %0d of %0d seen", name, got, n);
    end
  endtask

  // Program ends in a JAL to itself and no pulse may follow the last one
  task automatic run_program(input string name, input int n);
    emit(j_type(21'd0, 5'd0));
    csr_seen.delete();
    load_program();
    run = 1'b1;
    collect_pulses(name, n);
    repeat (20) begin
      @(negedge clk);
      if (csr_we) begin
        csr_seen.push_back(csr);
      end
    end
    run = 1'b0;
    repeat (4) @(negedge clk);
    check_count(name, n, csr_seen.size());
    compare_results(name);
  endtask

  task automatic idle_reset_test();
    int          pulses;
    logic [31:0] csr_bad;
    pulses = 0;
    csr_bad = '0;
    repeat (50) begin
      @(negedge clk);
      if (csr_we) begin
        pulses++;
      end
      if (csr !== 32'd0) begin
        csr_bad = csr;
      end
    end
    check_count("idle after reset", 0, pulses);
    check_word("idle after reset", '0, csr_bad);
  endtask

  task automatic alu_ops_test();
    logic [31:0] a, b, b_eff;
    logic [11:0] imm;
    logic [2:0]  f3;
    logic        alt;
    prog_q.delete();
    expect_q.delete();
    for (int k = 0; k < 19; k++) begin
      a = rand_word();
      b = rand_word();
      f3 = (k < 10) ? 3'(k) : 3'(k - 10);
      alt = (k == 8 || k == 9 || k == 18);  // SUB, SRA, SRAI
      if (k == 8) f3 = 3'b000;
      if (k == 9 || k == 18) f3 = 3'b101;
      load_const(5'd5, a);
      if (k < 10) begin
        load_const(5'd6, b);
        emit(r_type({1'b0, alt, 5'b0}, 5'd6, 5'd5, f3, 5'd7));
        b_eff = b;
      end else begin
        imm = (f3 == 3'b001 || f3 == 3'b101) ? {1'b0, alt, 5'b0, b[4:0]} : b[11:0];
        emit(i_type(imm, 5'd5, f3, 5'd7, op_imm));
        b_eff = {{20{imm[11]}}, imm};
      end
      write_tohost(5'd7);
      expect_q.push_back(alu_model(f3, alt, a, b_eff));
    end
    run_program("alu ops", 19);
  endtask

  task automatic forwarding_test();
    logic [31:0] v, c1, c2, r13, r14, r15, r16, r22, r23, r24, r25;
    prog_q.delete();
    expect_q.delete();
    v  = rand_word();
    c1 = rand_word();
    c2 = rand_word();
    load_const(5'd10, 32'h100);
    load_const(5'd11, v);
    emit(s_type(12'd0, 5'd11, 5'd10, 3'b010));
    emit(i_type(12'd0, 5'd10, 3'b010, 5'd12, op_load));
    emit(r_type(7'h00, 5'd12, 5'd12, 3'b000, 5'd13));  // Load then use
    emit(r_type(7'h20, 5'd12, 5'd13, 3'b000, 5'd14));
    emit(r_type(7'h00, 5'd13, 5'd14, 3'b100, 5'd15));
    emit(r_type(7'h00, 5'd14, 5'd15, 3'b000, 5'd16));
    emit(r_type(7'h20, 5'd15, 5'd16, 3'b000, 5'd17));
    write_tohost(5'd17);
    r13 = v + v;
    r14 = r13 - v;
    r15 = r14 ^ r13;
    r16 = r15 + r14;
    expect_q.push_back(r16 - r15);
    load_const(5'd20, c1);
    load_const(5'd21, c2);
    emit(r_type(7'h00, 5'd21, 5'd20, 3'b000, 5'd22));
    emit(r_type(7'h00, 5'd20, 5'd22, 3'b100, 5'd23));
    emit(r_type(7'h20, 5'd22, 5'd23, 3'b000, 5'd24));
    emit(r_type(7'h00, 5'd24, 5'd24, 3'b000, 5'd25));
    emit(r_type(7'h00, 5'd23, 5'd25, 3'b100, 5'd26));
    write_tohost(5'd26);
    r22 = c1 + c2;
    r23 = r22 ^ c1;
    r24 = r23 - r22;
    r25 = r24 + r24;
    expect_q.push_back(r25 ^ r23);
    run_program("forwarding", 2);
  endtask

  // Store cases are SB at 0..3, SH at 0 and 2, and SW
  task automatic memory_test();
    logic [31:0] bg, data, word;
    logic [2:0]  f3;
    logic [1:0]  off;
    prog_q.delete();
    expect_q.delete();
    for (int s = 0; s < 7; s++) begin
      f3 = (s < 4) ? 3'b000 : (s < 6) ? 3'b001 : 3'b010;
      off = (s < 4) ? 2'(s) : (s < 6) ? 2'((s - 4) * 2) : 2'd0;
      bg = rand_word();
      data = rand_word();
      load_const(5'd10, 32'h200 + 32'(s) * 32'd4);
      load_const(5'd11, bg);
      load_const(5'd12, data);
      emit(s_type(12'd0, 5'd11, 5'd10, 3'b010));
      emit(s_type({10'd0, off}, 5'd12, 5'd10, f3));
      word = store_merge(bg, data, f3, off);
      read_back(3'b010, 2'd0, word);
      for (int o = 0; o < 4; o++) begin
        read_back(3'b000, 2'(o), word);
        read_back(3'b100, 2'(o), word);
      end
      for (int o = 0; o < 4; o += 2) begin
        read_back(3'b001, 2'(o), word);
        read_back(3'b101, 2'(o), word);
      end
    end
    run_program("memory", 91);
  endtask

  task automatic control_flow_test();
    logic [31:0] a, b, tmp, p;
    logic [2:0]  f3;
    logic [4:0]  code;
    logic        want;
    prog_q.delete();
    expect_q.delete();
    code = 5'd0;
    for (int t = 0; t < 12; t++) begin
      f3 = (t < 4) ? 3'(t / 2) : 3'(t / 2 + 2);  // BEQ BNE BLT BGE BLTU BGEU
      want = t[0];
      a = rand_word();
      b = rand_word();
      if (a == b) b = a + 32'd1;
      if (f3[2] == 1'b0) begin
        if (branch_taken(f3, a, a) == want) b = a;
      end else if (branch_taken(f3, a, b) != want) begin
        tmp = a;
        a = b;
        b = tmp;
      end
      load_const(5'd5, a);
      load_const(5'd6, b);
      code = code + 5'd1;
      emit(b_type(13'd12, 5'd6, 5'd5, f3));
      if (want) begin
        write_tohost_imm(5'd31);  // Wrong-path markers
        write_tohost_imm(5'd31);
        write_tohost_imm(code);
      end else begin
        write_tohost_imm(code);
        emit(j_type(21'd12, 5'd0));
        write_tohost_imm(5'd31);
        write_tohost_imm(5'd31);
      end
      expect_q.push_back({27'd0, code});
    end
    p = next_pc();
    emit(j_type(21'd12, 5'd1));
    write_tohost_imm(5'd31);
    write_tohost_imm(5'd31);
    write_tohost(5'd1);
    expect_q.push_back(p + 32'd4);
    p = next_pc();
    emit(u_type(20'd0, 5'd7, op_auipc));
    emit(i_type(12'd17, 5'd7, 3'b000, 5'd1, op_jalr));  // Odd target with bit 0 dropped
    write_tohost_imm(5'd31);
    write_tohost_imm(5'd31);
    write_tohost(5'd1);
    expect_q.push_back(p + 32'd8);
    run_program("control flow", 14);
    foreach (csr_seen[i]) begin
      if (csr_seen[i] == 32'd31) begin
        value_errors++;
        $display("control flow: a wrong-path marker reached tohost at write %0d", i);
      end
    end
  endtask

  // Endless counting loop that only a drop of run can stop
  task automatic run_stop_test();
    logic [31:0] start;
    int          pulses;
    prog_q.delete();
    start = rand_word();
    load_const(5'd5, start);
    emit(i_type(12'd1, 5'd5, 3'b000, 5'd5, op_imm));
    write_tohost(5'd5);
    emit(j_type(21'h1ffff8, 5'd0));  // Back to the ADDI
    csr_seen.delete();
    load_program();
    run = 1'b1;
    collect_pulses("run stop", 4);
    run = 1'b0;
    repeat (4) @(negedge clk);  // Pipeline drain
    pulses = 0;
    repeat (50) begin
      @(negedge clk);
      if (csr_we) begin
        pulses++;
      end
    end
    check_count("run stop", 0, pulses);
    foreach (csr_seen[i]) begin
      check_word("run stop", start + 32'(i) + 32'd1, csr_seen[i]);
    end
  endtask

// File: tb/tb_riscv_core.sv
module tb_riscv_core import riscv_pkg::*; ();
  logic        clk;
  logic        rst_n;
  logic        run;
  prog_write_t prog;
  logic [31:0] csr;
  logic        csr_we;

  logic [31:0]     prog_q[$];    // Program under construction
  logic [xlen-1:0] csr_seen[$];  // Values seen on csr at each csr_we pulse
  logic [xlen-1:0] expect_q[$];
  logic [31:0]     lcg_state;
  int              value_errors;
  int              count_errors;
  int              timeout_errors;

  tb_clock u_clock (
    .clk  (clk),
    .rst_n(rst_n)
  );

  riscv_core u_riscv_core (
    .clk   (clk),
    .rst_n (rst_n),
    .run   (run),
    .prog  (prog),
    .csr   (csr),
    .csr_we(csr_we)
  );

  function automatic logic [31:0] rand_word();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // Reference models from the RV32I rules
  function automatic logic [31:0] alu_model(input logic [2:0] f3, input logic alt,
                                            input logic [31:0] a, input logic [31:0] b);
    case (f3)
      3'b000:  return alt ? a - b : a + b;
      3'b001:  return a << b[4:0];
      3'b010:  return {31'b0, $signed(a) < $signed(b)};
      3'b011:  return {31'b0, a < b};
      3'b100:  return a ^ b;
      3'b101: begin
        if (alt) begin
          return $signed(a) >>> b[4:0];
        end
        return a >> b[4:0];
      end
      3'b110:  return a | b;
      default: return a & b;
    endcase
  endfunction

  function automatic logic branch_taken(input logic [2:0] f3, input logic [31:0] a,
                                        input logic [31:0] b);
    case (f3)
      3'b000:  return a == b;
      3'b001:  return a != b;
      3'b100:  return $signed(a) < $signed(b);
      3'b101:  return $signed(a) >= $signed(b);
      3'b110:  return a < b;
      default: return a >= b;
    endcase
  endfunction

  function automatic logic [31:0] store_merge(input logic [31:0] old, input logic [31:0] data,
                                              input logic [2:0] f3, input logic [1:0] off);
    logic [31:0] w;
    w = old;
    case (f3[1:0])
      2'b00:   w[8*off +: 8] = data[7:0];
      2'b01:   w[8*off +: 16] = data[15:0];  // Offset is 0 or 2 here
      default: w = data;
    endcase
    return w;
  endfunction

  function automatic logic [31:0] load_extract(input logic [31:0] word, input logic [2:0] f3,
                                               input logic [1:0] off);
    logic [7:0]  b;
    logic [15:0] h;
    b = word[8*off +: 8];
    h = off[1] ? word[31:16] : word[15:0];
    case (f3)
      3'b000:  return {{24{b[7]}}, b};
      3'b100:  return {24'b0, b};
      3'b001:  return {{16{h[15]}}, h};
      3'b101:  return {16'b0, h};
      default: return word;
    endcase
  endfunction

  task automatic check_word(input string name, input logic [xlen-1:0] expected,
                            input logic [xlen-1:0] actual);
    if (actual !== expected) begin
      value_errors++;
      $display("error: expected %h, actual %h in %s", expected, actual, name);
    end
  endtask

  task automatic check_count(input string name, input int expected, input int actual);
    if (actual != expected) begin
      count_errors++;
      $display("error: expected %0d pulses, actual %0d in %s", expected, actual, name);
    end
  endtask

  task automatic compare_results(input string name);
    for (int i = 0; i < expect_q.size(); i++) begin
      if (i < csr_seen.size()) begin
        check_word($sformatf("%s, write %0d", name, i), expect_q[i], csr_seen[i]);
      end
    end
  endtask

  task automatic wait_reset();
    int waited;
    waited = 0;
    while (rst_n !== 1'b1 && waited < 20) begin
      @(negedge clk);
      waited++;
    end
    if (rst_n !== 1'b1) begin
      timeout_errors++;
      $display("reset was never released within 20 cycles");
    end
  endtask

  `include "tb_programs.svh"

  initial begin
    run            = 1'b0;
    prog           = '0;
    lcg_state      = 32'hdf09;
    value_errors   = 0;
    count_errors   = 0;
    timeout_errors = 0;
    wait_reset();
    idle_reset_test();
    alu_ops_test();
    forwarding_test();
    memory_test();
    control_flow_test();
    run_stop_test();
    $display("errors: %0d value, %0d count, %0d timeout",
             value_errors, count_errors, timeout_errors);
    if (value_errors + count_errors + timeout_errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

// File: vlog.f
+incdir+tb
common/riscv_pkg.sv
source/sync_ram_wbe.sv
fetch/fetch_unit.sv
decode/reg_file.sv
decode/decode_stage.sv
execute/execute_stage.sv
execute/mem_align.sv
source/riscv_core.sv
tb/tb_clock.sv
tb/tb_riscv_core.sv

// File: run.sh
#!/bin/sh
# Build and run the riscv_core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary -Wno-fatal --top-module tb_riscv_core -f vlog.f -o sim_tb > build.log 2>&1
if [ $? -ne 0 ]; then
  echo "build failed, see build.log"
  exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
if [ $? -ne 0 ]; then
  echo "simulation exited with an error, see sim.log"
  exit 1
fi

if grep -q "^TEST PASS$" sim.log; then
  echo "simulation passed"
  exit 0
else
  echo "simulation failed, see sim.log"
  exit 1
fi
